// ==== Makefile ====
TOP = tb_fp51_timer_periph

.PHONY: all compile run clean

all: run

compile:
	verilator --binary --timing --assert --top-module $(TOP) -f fp51_timer_periph.f -o $(TOP)

run: compile
	./obj_dir/$(TOP) > sim.log 2>&1 || true
	cat sim.log
	@if grep -q "sim failed" sim.log; then \
		echo "Simulation reported failure"; \
		exit 1; \
	fi
	@if ! grep -q "sim passed" sim.log; then \
		echo "Simulation ended without a result"; \
		exit 1; \
	fi

clean:
	rm -rf obj_dir sim.log

// ==== fp51_int_ctrl.sv ====
`default_nettype none
`timescale 1ns/1ns

module fp51_int_ctrl (
    input  wire                             clk,
    input  wire                             reset_n,

    input  wire [1:0]                       ext_int_i,
    input  wire                             ovf0_i,
    input  wire                             ovf1_i,
    input  wire fp51_timer_pkg::sfr_data_t  ie_i,
    input  wire fp51_timer_pkg::sfr_data_t  ip_i,
    input  wire                             int_ret_i,

    // Synchronized pin levels, also used for timer gating
    output logic [1:0]                      ext_lvl_o,
    output logic                            int_gen_o,
    output fp51_timer_pkg::sfr_data_t       int_addr_o
);
    import fp51_timer_pkg::*;

    logic [1:0]                 ext_meta;
    logic [1:0]                 ext_sync;
    logic                       tmr0_pend;
    logic                       tmr1_pend;
    int_src_t                   src;
    int_src_t                   enable;
    int_src_t                   req;
    int_src_t                   req_hi;
    int_src_t                   cand;
    int_src_t                   grant;
    logic [$clog2(NUM_INT)-1:0] win_idx;
    sfr_data_t                  vec;
    int_state_t                 state_q;
    logic                       issue;

    // ======================================================================
    // Pin synchronizer
    // ======================================================================
    always_ff @(posedge clk, negedge reset_n) begin
        if (!reset_n) begin
            ext_meta <= '0;
            ext_sync <= '0;
        end else begin
            ext_meta <= ext_int_i;
            ext_sync <= ext_meta;
        end
    end

    assign ext_lvl_o = ext_sync;

    // Timer pending bits, a new overflow beats the issue clear
    always_ff @(posedge clk, negedge reset_n) begin
        if (!reset_n) begin
            tmr0_pend <= 1'b0;
            tmr1_pend <= 1'b0;
        end else begin
            tmr0_pend <= ovf0_i || (tmr0_pend && !(issue && grant[INT_TMR0]));
            tmr1_pend <= ovf1_i || (tmr1_pend && !(issue && grant[INT_TMR1]));
        end
    end

    // ======================================================================
    // Request and priority
    // ======================================================================
    // Ext sources are level, timers pending
    assign src[INT_EXT0] = ext_sync[0];
    assign src[INT_TMR0] = tmr0_pend;
    assign src[INT_EXT1] = ext_sync[1];
    assign src[INT_TMR1] = tmr1_pend;

    assign enable = {ie_i[IE_ET1], ie_i[IE_EX1], ie_i[IE_ET0], ie_i[IE_EX0]};
    assign req    = ie_i[IE_EA] ? (src & enable) : '0;

    // High level first, else all requests
    assign req_hi = req & ip_i[NUM_INT-1:0];
    assign cand   = (|req_hi) ? req_hi : req;

    // Lowest index wins
    always_comb begin
        win_idx = '0;
        for (int k = NUM_INT - 1; k >= 0; k--) begin
            if (cand[k]) begin
                win_idx = ($bits(win_idx))'(k);
            end
        end
    end

    assign grant = int_src_t'(1) << win_idx;
    assign vec   = sfr_data_t'(win_idx) * INT_VEC_STEP + INT_VEC_BASE;
    assign issue = (state_q == IDLE) && (|req);

    // ======================================================================
    // Issue FSM
    // ======================================================================
    always_ff @(posedge clk, negedge reset_n) begin
        if (!reset_n) begin
            state_q    <= IDLE;
            int_gen_o  <= 1'b0;
            int_addr_o <= '0;
        end else begin
            int_gen_o <= 1'b0;
            case (state_q)
                IDLE: begin
                    if (issue) begin
                        state_q    <= IN_SERVICE;
                        int_gen_o  <= 1'b1;
                        int_addr_o <= vec;
                    end
                end
                IN_SERVICE: begin
                    // Wait for return, no nesting
                    if (int_ret_i) begin
                        state_q <= IDLE;
                    end
                end
                default: state_q <= IDLE;
            endcase
        end
    end

    int_gen_single: assert property (
        @(posedge clk) disable iff (!reset_n)
        int_gen_o |=> !int_gen_o
    );

    // Granted source is a candidate, no lower index candidate left out
    grant_lowest: assert property (
        @(posedge clk) disable iff (!reset_n)
        issue |-> (((grant & cand) != '0) && ((cand & (grant - int_src_t'(1))) == '0))
    );

endmodule

`default_nettype wire

// ==== fp51_sfr_regs.sv ====
`default_nettype none
`timescale 1ns/1ns

module fp51_sfr_regs (
    input  wire                             clk,
    input  wire                             reset_n,

    // Read side, combinational on address
    input  wire fp51_timer_pkg::sfr_addr_t  rd_adr_i,
    output fp51_timer_pkg::sfr_data_t       rd_dat_o,

    // Write side
    input  wire                             wr_stb_i,
    input  wire                             wr_we_i,
    input  wire fp51_timer_pkg::sfr_addr_t  wr_adr_i,
    input  wire fp51_timer_pkg::sfr_data_t  wr_dat_i,

    // Timer values and overflow pulses
    input  wire fp51_timer_pkg::sfr_data_t  th0_i,
    input  wire fp51_timer_pkg::sfr_data_t  tl0_i,
    input  wire fp51_timer_pkg::sfr_data_t  th1_i,
    input  wire fp51_timer_pkg::sfr_data_t  tl1_i,
    input  wire                             ovf0_i,
    input  wire                             ovf1_i,

    // Timer control out
    output logic                            run0_o,
    output logic                            run1_o,
    output logic                            gate0_o,
    output logic                            gate1_o,
    output logic [1:0]                      mode0_o,
    output logic [1:0]                      mode1_o,

    // Interrupt control out
    output fp51_timer_pkg::sfr_data_t       ie_o,
    output fp51_timer_pkg::sfr_data_t       ip_o
);
    import fp51_timer_pkg::*;

    sfr_data_t ie_q;
    sfr_data_t ip_q;
    sfr_data_t tmod_q;
    sfr_data_t tcon_q;
    logic      wr_en;

    assign wr_en = wr_stb_i && wr_we_i;

    // ======================================================================
    // IE / IP / TMOD
    // ======================================================================
    always_ff @(posedge clk, negedge reset_n) begin
        if (!reset_n) begin
            ie_q   <= '0;
            ip_q   <= '0;
            tmod_q <= '0;
        end else if (wr_en) begin
            case (wr_adr_i)
                ADDR_IE:   ie_q   <= wr_dat_i;
                ADDR_IP:   ip_q   <= wr_dat_i;
                ADDR_TMOD: tmod_q <= wr_dat_i;
                default: ;
            endcase
        end
    end

    // ======================================================================
    // TCON, flags set by overflow
    // ======================================================================
    always_ff @(posedge clk, negedge reset_n) begin
        if (!reset_n) begin
            tcon_q <= '0;
        end else if (wr_en && (wr_adr_i == ADDR_TCON)) begin
            // Write overrides flag setting
            tcon_q <= wr_dat_i;
        end else begin
            // Both timers may flag in one cycle
            if (ovf0_i) begin
                tcon_q[TCON_TF0] <= 1'b1;
            end
            if (ovf1_i) begin
                tcon_q[TCON_TF1] <= 1'b1;
            end
        end
    end

    // Read data mux, unmapped reads 0
    always_comb begin
        case (rd_adr_i)
            ADDR_TCON: rd_dat_o = tcon_q;
            ADDR_TMOD: rd_dat_o = tmod_q;
            ADDR_TL0:  rd_dat_o = tl0_i;
            ADDR_TL1:  rd_dat_o = tl1_i;
            ADDR_TH0:  rd_dat_o = th0_i;
            ADDR_TH1:  rd_dat_o = th1_i;
            ADDR_IE:   rd_dat_o = ie_q;
            ADDR_IP:   rd_dat_o = ip_q;
            default:   rd_dat_o = '0;
        endcase
    end

    // Control fields
    assign run0_o  = tcon_q[TCON_TR0];
    assign run1_o  = tcon_q[TCON_TR1];
    assign gate0_o = tmod_q[TMOD_GATE0];
    assign gate1_o = tmod_q[TMOD_GATE1];
    assign mode0_o = tmod_q[TMOD_MODE0_LSB +: 2];
    assign mode1_o = tmod_q[TMOD_MODE1_LSB +: 2];
    assign ie_o    = ie_q;
    assign ip_o    = ip_q;

endmodule

`default_nettype wire

// ==== fp51_timer.sv ====
`default_nettype none
`timescale 1ns/1ns

module fp51_timer #(
    parameter fp51_timer_pkg::sfr_addr_t th_addr = fp51_timer_pkg::ADDR_TH0,
    parameter fp51_timer_pkg::sfr_addr_t tl_addr = fp51_timer_pkg::ADDR_TL0
) (
    input  wire                             clk,
    input  wire                             reset_n,

    // Write side of the SFR bus
    input  wire                             wr_stb_i,
    input  wire                             wr_we_i,
    input  wire fp51_timer_pkg::sfr_addr_t  wr_adr_i,
    input  wire fp51_timer_pkg::sfr_data_t  wr_dat_i,

    // Control from TCON / TMOD
    input  wire                             run_i,
    input  wire                             gate_i,
    input  wire                             ext_lvl_i,
    input  wire [1:0]                       mode_i,

    output fp51_timer_pkg::sfr_data_t       th_o,
    output fp51_timer_pkg::sfr_data_t       tl_o,
    output logic                            ovf_o
);
    import fp51_timer_pkg::*;

    sfr_data_t th_q;
    sfr_data_t tl_q;
    logic      th_wr;
    logic      tl_wr;
    logic      count_en;
    logic      wrap;

    // Own address decode
    assign th_wr = wr_stb_i && wr_we_i && (wr_adr_i == th_addr);
    assign tl_wr = wr_stb_i && wr_we_i && (wr_adr_i == tl_addr);

    // Runs in modes 1/2 only, gate lets the ext pin hold it off
    assign count_en = run_i &&
                      ((mode_i == TMODE_16BIT) || (mode_i == TMODE_RELOAD)) &&
                      (!gate_i || ext_lvl_i);

    // Wrap condition for the current mode
    always_comb begin
        if (mode_i == TMODE_16BIT) begin
            wrap = (th_q == 8'hFF) && (tl_q == 8'hFF);
        end else begin
            wrap = (tl_q == 8'hFF);
        end
    end

    // ======================================================================
    // TH / TL counter
    // ======================================================================
    always_ff @(posedge clk, negedge reset_n) begin
        if (!reset_n) begin
            th_q <= '0;
            tl_q <= '0;
        end else if (th_wr || tl_wr) begin
            // Bus write wins over counting
            if (th_wr) begin
                th_q <= wr_dat_i;
            end
            if (tl_wr) begin
                tl_q <= wr_dat_i;
            end
        end else if (count_en) begin
            if (mode_i == TMODE_16BIT) begin
                {th_q, tl_q} <= {th_q, tl_q} + 16'd1;
            end else if (wrap) begin
                // Mode 2 reload from TH
                tl_q <= th_q;
            end else begin
                tl_q <= tl_q + 8'd1;
            end
        end
    end

    // One cycle overflow pulse, after the wrapping edge
    always_ff @(posedge clk, negedge reset_n) begin
        if (!reset_n) begin
            ovf_o <= 1'b0;
        end else begin
            ovf_o <= count_en && wrap && !(th_wr || tl_wr);
        end
    end

    assign th_o = th_q;
    assign tl_o = tl_q;

    // Back-to-back overflow only possible with a reload value of FFh
    ovf_single_pulse: assert property (
        @(posedge clk) disable iff (!reset_n)
        (ovf_o && (th_q != 8'hFF)) |=> !ovf_o
    );

endmodule

`default_nettype wire

// ==== fp51_timer_periph.f ====
fp51_timer_pkg.sv
fp51_timer.sv
fp51_sfr_regs.sv
fp51_int_ctrl.sv
fp51_timer_periph.sv
tb_fp51_timer_periph.sv

// ==== fp51_timer_periph.sv ====
`default_nettype none
`timescale 1ns/1ns

module fp51_timer_periph (
    input  wire                             clk,
    input  wire                             reset_n,

    // Read side
    input  wire                             rd_stb_i,
    input  wire fp51_timer_pkg::sfr_addr_t  rd_adr_i,
    output fp51_timer_pkg::sfr_data_t       rd_dat_o,
    output logic                            rd_ack_o,

    // Write side
    input  wire                             wr_stb_i,
    input  wire                             wr_we_i,
    input  wire fp51_timer_pkg::sfr_addr_t  wr_adr_i,
    input  wire fp51_timer_pkg::sfr_data_t  wr_dat_i,
    output logic                            wr_ack_o,

    // Interrupts
    input  wire [1:0]                       ext_int_i,
    input  wire                             int_ret_i,
    output logic                            int_gen_o,
    output fp51_timer_pkg::sfr_data_t       int_addr_o,

    // Toggles on every timer 0 overflow
    output logic                            timer_pulse_o
);
    import fp51_timer_pkg::*;

    sfr_data_t  th0;
    sfr_data_t  tl0;
    sfr_data_t  th1;
    sfr_data_t  tl1;
    sfr_data_t  ie;
    sfr_data_t  ip;
    logic       ovf0;
    logic       ovf1;
    logic       run0;
    logic       run1;
    logic       gate0;
    logic       gate1;
    logic [1:0] mode0;
    logic [1:0] mode1;
    logic [1:0] ext_lvl;

    // No wait states
    assign rd_ack_o = rd_stb_i;
    assign wr_ack_o = wr_stb_i;

    // ======================================================================
    // Registers and read mux
    // ======================================================================
    fp51_sfr_regs i_sfr_regs (
        .clk, .reset_n, .rd_adr_i, .rd_dat_o,
        .wr_stb_i, .wr_we_i, .wr_adr_i, .wr_dat_i,
        .th0_i (th0), .tl0_i (tl0), .th1_i (th1), .tl1_i (tl1),
        .ovf0_i (ovf0), .ovf1_i (ovf1),
        .run0_o (run0), .run1_o (run1),
        .gate0_o (gate0), .gate1_o (gate1),
        .mode0_o (mode0), .mode1_o (mode1),
        .ie_o (ie), .ip_o (ip)
    );

    // ======================================================================
    // Timers
    // ======================================================================
    fp51_timer #(.th_addr (ADDR_TH0), .tl_addr (ADDR_TL0)) i_timer0 (
        .clk, .reset_n, .wr_stb_i, .wr_we_i, .wr_adr_i, .wr_dat_i,
        .run_i (run0), .gate_i (gate0), .ext_lvl_i (ext_lvl[0]), .mode_i (mode0),
        .th_o (th0), .tl_o (tl0), .ovf_o (ovf0)
    );

    fp51_timer #(.th_addr (ADDR_TH1), .tl_addr (ADDR_TL1)) i_timer1 (
        .clk, .reset_n, .wr_stb_i, .wr_we_i, .wr_adr_i, .wr_dat_i,
        .run_i (run1), .gate_i (gate1), .ext_lvl_i (ext_lvl[1]), .mode_i (mode1),
        .th_o (th1), .tl_o (tl1), .ovf_o (ovf1)
    );

    // Toggle flop, lines up with TF0
    always_ff @(posedge clk, negedge reset_n) begin
        if (!reset_n) begin
            timer_pulse_o <= 1'b0;
        end else if (ovf0) begin
            timer_pulse_o <= !timer_pulse_o;
        end
    end

    // ======================================================================
    // Interrupt controller
    // ======================================================================
    fp51_int_ctrl i_int_ctrl (
        .clk, .reset_n, .ext_int_i,
        .ovf0_i (ovf0), .ovf1_i (ovf1),
        .ie_i (ie), .ip_i (ip), .int_ret_i,
        .ext_lvl_o (ext_lvl), .int_gen_o, .int_addr_o
    );

endmodule

`default_nettype wire

// ==== fp51_timer_pkg.sv ====
`default_nettype none

package fp51_timer_pkg;

    // ======================================================================
    // Widths and types
    // ======================================================================

    // Interrupt sources handled by the controller
    localparam int NUM_INT = 4;

    typedef logic [7:0] sfr_addr_t;
    typedef logic [7:0] sfr_data_t;

    // One bit per source, ext0 / timer0 / ext1 / timer1
    typedef logic [NUM_INT-1:0] int_src_t;

    // Controller holds one request at a time, no nesting
    typedef enum logic [0:0] {
        IDLE,
        IN_SERVICE
    } int_state_t;

    // ======================================================================
    // SFR addresses
    // ======================================================================
    localparam sfr_addr_t ADDR_TCON = 8'h88;
    localparam sfr_addr_t ADDR_TMOD = 8'h89;
    localparam sfr_addr_t ADDR_TL0  = 8'h8A;
    localparam sfr_addr_t ADDR_TL1  = 8'h8B;
    localparam sfr_addr_t ADDR_TH0  = 8'h8C;
    localparam sfr_addr_t ADDR_TH1  = 8'h8D;
    localparam sfr_addr_t ADDR_IE   = 8'hA8;
    localparam sfr_addr_t ADDR_IP   = 8'hB8;

    // TCON bits, low nibble is plain storage
    localparam int TCON_TF1 = 7;
    localparam int TCON_TR1 = 6;
    localparam int TCON_TF0 = 5;
    localparam int TCON_TR0 = 4;

    // IE bits
    localparam int IE_EA  = 7;
    localparam int IE_ET1 = 3;
    localparam int IE_EX1 = 2;
    localparam int IE_ET0 = 1;
    localparam int IE_EX0 = 0;

    // TMOD layout, C/T bits kept but unused
    localparam int TMOD_GATE1     = 7;
    localparam int TMOD_MODE1_LSB = 4;
    localparam int TMOD_GATE0     = 3;
    localparam int TMOD_MODE0_LSB = 0;

    // Supported timer modes, 0 and 3 hold the count
    localparam logic [1:0] TMODE_16BIT  = 2'd1;
    localparam logic [1:0] TMODE_RELOAD = 2'd2;

    // ======================================================================
    // Interrupt sources and vectors
    // ======================================================================
    localparam int INT_EXT0 = 0;
    localparam int INT_TMR0 = 1;
    localparam int INT_EXT1 = 2;
    localparam int INT_TMR1 = 3;

    // Vector k = base + k * step
    localparam sfr_data_t INT_VEC_BASE = 8'h03;
    localparam sfr_data_t INT_VEC_STEP = 8'h08;

endpackage

`default_nettype wire

// ==== tb_fp51_timer_periph.sv ====
`default_nettype none
`timescale 1ns/1ns

module tb_fp51_timer_periph;
    import fp51_timer_pkg::*;

    localparam int RUN_TIMEOUT  = 200;
    localparam int INT_TIMEOUT  = 50;
    localparam int QUIET_CYCLES = 24;
    localparam int NUM_ROUNDS   = 24;

    logic        clk;
    logic        reset_n;
    logic        rd_stb;
    sfr_addr_t   rd_adr;
    sfr_data_t   rd_dat;
    logic        rd_ack;
    logic        wr_stb;
    logic        wr_we;
    sfr_addr_t   wr_adr;
    sfr_data_t   wr_dat;
    logic        wr_ack;
    logic [1:0]  ext_int;
    logic        int_ret;
    logic        int_gen;
    sfr_data_t   int_addr;
    logic        timer_pulse;

    // Model state
    logic [31:0] lcg_state;
    sfr_data_t   tmod_model;
    logic        pulse_model;
    logic [1:0]  ext_model;
    // Timer pending bits, index 0 is timer 0
    logic [1:0]  pend_model;

    fp51_timer_periph i_fp51_timer_periph (
        .clk           (clk),
        .reset_n       (reset_n),
        .rd_stb_i      (rd_stb),
        .rd_adr_i      (rd_adr),
        .rd_dat_o      (rd_dat),
        .rd_ack_o      (rd_ack),
        .wr_stb_i      (wr_stb),
        .wr_we_i       (wr_we),
        .wr_adr_i      (wr_adr),
        .wr_dat_i      (wr_dat),
        .wr_ack_o      (wr_ack),
        .ext_int_i     (ext_int),
        .int_ret_i     (int_ret),
        .int_gen_o     (int_gen),
        .int_addr_o    (int_addr),
        .timer_pulse_o (timer_pulse)
    );

    initial begin
        clk = 1'b0;
        forever begin
            #10 clk = ~clk;
        end
    end

    // ========================================================================
    // Random numbers and reporting
    // ========================================================================
    function automatic logic [31:0] next_rand();
        lcg_state = lcg_state * 32'd1664525 + 32'd1013904223;
        return lcg_state;
    endfunction

    // Upper bits of the LCG are the better ones
    function automatic sfr_data_t rand_byte();
        logic [31:0] r;
        r = next_rand();
        return r[31:24];
    endfunction

    task automatic fail_now(input string msg);
        $display("%s", msg);
        $display("sim failed");
        $fatal(1, "stopped at first error");
    endtask

    task automatic check_data(input string name, input sfr_data_t exp, input sfr_data_t act);
        if (act !== exp) begin
            fail_now($sformatf("FAILED %s: expected %02h, actual %02h", name, exp, act));
        end
    endtask

    task automatic check_vec(input string name, input sfr_data_t exp, input sfr_data_t act);
        if (act !== exp) begin
            fail_now($sformatf("FAILED %s: expected vector %02h, actual %02h", name, exp, act));
        end
    endtask

    task automatic check_bit(input string name, input logic exp, input logic act);
        if (act !== exp) begin
            fail_now($sformatf("FAILED %s: expected %b, actual %b", name, exp, act));
        end
    endtask

    // ========================================================================
    // Bus access
    // ========================================================================
    // One write per call, effective at the rising edge in between
    task automatic bus_write(input sfr_addr_t adr, input sfr_data_t dat);
        @(negedge clk);
        wr_stb = 1'b1;
        wr_we  = 1'b1;
        wr_adr = adr;
        wr_dat = dat;
        #2;
        if (wr_ack !== 1'b1) begin
            fail_now("write ack stayed low while the write strobe was high");
        end
        @(negedge clk);
        wr_stb = 1'b0;
        wr_we  = 1'b0;
        #2;
        if (wr_ack !== 1'b0) begin
            fail_now("write ack was high without a write strobe");
        end
    endtask

    // Read within the current low phase, no clock edge passes
    task automatic read_now(input sfr_addr_t adr, output sfr_data_t dat);
        rd_stb = 1'b1;
        rd_adr = adr;
        #1;
        if (rd_ack !== 1'b1) begin
            fail_now("read ack stayed low while the read strobe was high");
        end
        dat    = rd_dat;
        rd_stb = 1'b0;
        #1;
        if (rd_ack !== 1'b0) begin
            fail_now("read ack was high without a read strobe");
        end
    endtask

    task automatic read_reg(input sfr_addr_t adr, output sfr_data_t dat);
        @(negedge clk);
        read_now(adr, dat);
    endtask

    // TH and TL in the same cycle
    task automatic read_count(input logic tmr, output logic [15:0] cnt);
        sfr_data_t th;
        sfr_data_t tl;
        @(negedge clk);
        read_now(tmr ? ADDR_TH1 : ADDR_TH0, th);
        read_now(tmr ? ADDR_TL1 : ADDR_TL0, tl);
        cnt = {th, tl};
    endtask

    function automatic logic is_mapped(input sfr_addr_t adr);
        return (adr == ADDR_TCON) || (adr == ADDR_TMOD) || (adr == ADDR_TL0) ||
               (adr == ADDR_TL1) || (adr == ADDR_TH0) || (adr == ADDR_TH1) ||
               (adr == ADDR_IE) || (adr == ADDR_IP);
    endfunction

    // ========================================================================
    // Reference model
    // ========================================================================
    // One count step, mode 1 is 16 bit, mode 2 reloads TL from TH
    function automatic logic [15:0] count_tick(input logic [1:0] mode, input logic [15:0] cnt);
        logic [15:0] nxt;
        if (mode == 2'd1) begin
            nxt = cnt + 16'd1;
        end else if (cnt[7:0] == 8'hFF) begin
            nxt = {cnt[15:8], cnt[15:8]};
        end else begin
            nxt = {cnt[15:8], cnt[7:0] + 8'd1};
        end
        return nxt;
    endfunction

    // Count right after the wrapping edge
    function automatic logic [15:0] wrap_value(input logic [1:0] mode, input sfr_data_t th);
        return (mode == 2'd1) ? 16'h0000 : {th, th};
    endfunction

    function automatic int_src_t model_req(input sfr_data_t ie);
        int_src_t src;
        int_src_t en;
        src = {pend_model[1], ext_model[1], pend_model[0], ext_model[0]};
        en  = {ie[IE_ET1], ie[IE_EX1], ie[IE_ET0], ie[IE_EX0]};
        return ie[IE_EA] ? (src & en) : int_src_t'(0);
    endfunction

    // High priority requests first, lowest index within a level
    function automatic int model_winner(input int_src_t req, input sfr_data_t ip);
        int_src_t pick;
        int       win;
        int       k;
        pick = ((req & ip[3:0]) != '0) ? (req & ip[3:0]) : req;
        win  = 0;
        for (k = NUM_INT - 1; k >= 0; k--) begin
            if (pick[k]) begin
                win = k;
            end
        end
        return win;
    endfunction

    function automatic sfr_data_t model_vec(input int win);
        return INT_VEC_BASE + sfr_data_t'(win) * INT_VEC_STEP;
    endfunction

    // ========================================================================
    // Timer helpers
    // ========================================================================
    // Start a timer from th/tl, wait for its flag, check the count, then stop
    task automatic run_to_overflow(input logic tmr, input sfr_data_t th, input sfr_data_t tl);
        sfr_data_t   tcon;
        sfr_data_t   th_rd;
        sfr_data_t   tl_rd;
        logic [1:0]  mode;
        logic [15:0] exp_cnt;
        int          tf_bit;
        int          n;
        mode   = tmr ? tmod_model[5:4] : tmod_model[1:0];
        tf_bit = tmr ? TCON_TF1 : TCON_TF0;
        bus_write(tmr ? ADDR_TH1 : ADDR_TH0, th);
        bus_write(tmr ? ADDR_TL1 : ADDR_TL0, tl);
        tcon = '0;
        tcon[tmr ? TCON_TR1 : TCON_TR0] = 1'b1;
        bus_write(ADDR_TCON, tcon);
        n = 0;
        while (tcon[tf_bit] !== 1'b1) begin
            if (n == RUN_TIMEOUT) begin
                fail_now("timeout waiting for the timer overflow flag");
            end
            n++;
            @(negedge clk);
            read_now(ADDR_TCON, tcon);
        end
        // Flag shows one tick after the wrap
        read_now(tmr ? ADDR_TH1 : ADDR_TH0, th_rd);
        read_now(tmr ? ADDR_TL1 : ADDR_TL0, tl_rd);
        exp_cnt = count_tick(mode, wrap_value(mode, th));
        check_data($sformatf("TH%0d after overflow", tmr), exp_cnt[15:8], th_rd);
        check_data($sformatf("TL%0d after overflow", tmr), exp_cnt[7:0], tl_rd);
        if (!tmr) begin
            pulse_model = !pulse_model;
        end
        check_bit("timer_pulse_o", pulse_model, timer_pulse);
        pend_model[tmr] = 1'b1;
        // Stop with the flag kept, then clear it
        tcon = '0;
        tcon[tf_bit] = 1'b1;
        bus_write(ADDR_TCON, tcon);
        bus_write(ADDR_TCON, 8'h00);
        read_reg(ADDR_TCON, tcon);
        check_data($sformatf("TCON after TF%0d clear", tmr), 8'h00, tcon);
    endtask

    // ========================================================================
    // Interrupt helpers
    // ========================================================================
    task automatic expect_int(input sfr_data_t exp_vec);
        int n;
        n = 0;
        @(negedge clk);
        while (int_gen !== 1'b1) begin
            if (n == INT_TIMEOUT) begin
                fail_now("timeout waiting for int_gen_o");
            end
            n++;
            @(negedge clk);
        end
        check_vec("int_addr_o", exp_vec, int_addr);
    endtask

    task automatic expect_quiet(input int cycles);
        repeat (cycles) begin
            @(negedge clk);
            if (int_gen !== 1'b0) begin
                fail_now("int_gen_o rose when no interrupt was expected");
            end
        end
    endtask

    task automatic return_from_int();
        @(negedge clk);
        int_ret = 1'b1;
        @(negedge clk);
        int_ret = 1'b0;
    endtask

    // Random sources, enables and priorities, then serve all requests
    task automatic int_round();
        sfr_data_t r;
        sfr_data_t ie;
        sfr_data_t ip;
        int_src_t  req;
        int        win;
        int        served;
        r = rand_byte();
        // Sources are set up with EA clear
        bus_write(ADDR_IE, 8'h00);
        tmod_model = 8'h11;
        bus_write(ADDR_TMOD, tmod_model);
        if (r[0]) begin
            run_to_overflow(1'b0, 8'hFF, {5'b11111, r[3:1]});
        end
        if (r[1]) begin
            run_to_overflow(1'b1, 8'hFF, {5'b11110, r[4:2]});
        end
        @(negedge clk);
        ext_int   = r[5:4];
        ext_model = r[5:4];
        // Let the pins pass the synchronizer
        repeat (4) @(negedge clk);
        ip = rand_byte();
        ie = rand_byte();
        ie[IE_EA] = (r[7:6] != 2'b00);
        bus_write(ADDR_IP, ip);
        bus_write(ADDR_IE, ie);
        req    = model_req(ie);
        served = 0;
        while (req != '0) begin
            if (served == NUM_INT) begin
                fail_now("interrupt requests were not cleared by service");
            end
            win = model_winner(req, ip);
            expect_int(model_vec(win));
            case (win)
                INT_EXT0: begin
                    ext_int[0]   = 1'b0;
                    ext_model[0] = 1'b0;
                end
                INT_TMR0: pend_model[0] = 1'b0;
                INT_EXT1: begin
                    ext_int[1]   = 1'b0;
                    ext_model[1] = 1'b0;
                end
                default: pend_model[1] = 1'b0;
            endcase
            // No nesting while in service
            expect_quiet(8);
            return_from_int();
            req = model_req(ie);
            served++;
        end
        expect_quiet(QUIET_CYCLES);
    endtask

    // ========================================================================
    // Test sequence
    // ========================================================================
    initial begin
        sfr_data_t   d;
        sfr_data_t   ie;
        sfr_data_t   ip;
        sfr_data_t   tmod;
        sfr_data_t   tcon;
        sfr_addr_t   adr;
        logic [31:0] r;
        logic [15:0] cnt;
        logic [15:0] cnt_rd;
        int          i;
        int          n;

        lcg_state   = 32'h1de6c42c;
        pulse_model = 1'b0;
        ext_model   = 2'b00;
        pend_model  = 2'b00;
        tmod_model  = 8'h00;
        reset_n     = 1'b0;
        rd_stb      = 1'b0;
        rd_adr      = '0;
        wr_stb      = 1'b0;
        wr_we       = 1'b0;
        wr_adr      = '0;
        wr_dat      = '0;
        ext_int     = 2'b00;
        int_ret     = 1'b0;
        repeat (16) @(negedge clk);
        reset_n = 1'b1;

        @(negedge clk);
        check_bit("int_gen_o after reset", 1'b0, int_gen);
        check_bit("timer_pulse_o after reset", 1'b0, timer_pulse);
        check_vec("int_addr_o after reset", 8'h00, int_addr);

        // Register read back, timers kept stopped
        for (i = 0; i < 8; i++) begin
            ie   = rand_byte();
            ip   = rand_byte();
            tmod = rand_byte();
            tcon = rand_byte() & 8'hAF;
            bus_write(ADDR_IE, ie);
            bus_write(ADDR_IP, ip);
            bus_write(ADDR_TMOD, tmod);
            bus_write(ADDR_TCON, tcon);
            read_reg(ADDR_IE, d);
            check_data("IE read back", ie, d);
            read_reg(ADDR_IP, d);
            check_data("IP read back", ip, d);
            read_reg(ADDR_TMOD, d);
            check_data("TMOD read back", tmod, d);
            read_reg(ADDR_TCON, d);
            check_data("TCON read back", tcon, d);
        end
        for (i = 0; i < 16; i++) begin
            adr = rand_byte();
            if (is_mapped(adr)) begin
                adr = 8'h00;
            end
            read_reg(adr, d);
            check_data($sformatf("unmapped read at %02h", adr), 8'h00, d);
        end
        bus_write(ADDR_IE, 8'h00);
        bus_write(ADDR_IP, 8'h00);
        bus_write(ADDR_TCON, 8'h00);

        // Mode 1 on timer 0
        tmod_model = 8'h01;
        bus_write(ADDR_TMOD, tmod_model);
        run_to_overflow(1'b0, 8'hFF, 8'hF0 | (rand_byte() & 8'h0F));

        // Mode 2 on timer 1
        tmod_model = 8'h20;
        bus_write(ADDR_TMOD, tmod_model);
        run_to_overflow(1'b1, rand_byte(), 8'hF0 | (rand_byte() & 8'h0F));

        // Gating of timer 0 by the ext0 pin
        tmod_model = 8'h09;
        bus_write(ADDR_TMOD, tmod_model);
        r   = next_rand();
        cnt = {1'b0, r[30:16]};
        bus_write(ADDR_TH0, cnt[15:8]);
        bus_write(ADDR_TL0, cnt[7:0]);
        bus_write(ADDR_TCON, 8'h10);
        for (i = 0; i < 4; i++) begin
            r = next_rand();
            repeat (1 + int'(r[27:24])) @(negedge clk);
            read_count(1'b0, cnt_rd);
            check_data("TH0 while gated", cnt[15:8], cnt_rd[15:8]);
            check_data("TL0 while gated", cnt[7:0], cnt_rd[7:0]);
        end
        @(negedge clk);
        ext_int[0]   = 1'b1;
        ext_model[0] = 1'b1;
        n = 0;
        cnt_rd = cnt;
        while (cnt_rd == cnt) begin
            if (n == 10) begin
                fail_now("timer 0 did not advance after the gate pin went high");
            end
            n++;
            read_count(1'b0, cnt_rd);
        end
        bus_write(ADDR_TCON, 8'h00);
        ext_int[0]   = 1'b0;
        ext_model[0] = 1'b0;

        // Interrupt controller
        for (i = 0; i < NUM_ROUNDS; i++) begin
            int_round();
        end

        $display("sim passed");
        $finish;
    end

endmodule

`default_nettype wire
